//--- common/noc_pkg.sv
// ----------------------------------------
// noc router shared definitions
// port indices, coordinates, flit and port vector types
// ----------------------------------------

package noc_pkg;

  // router ports
  localparam int NUM_PORTS  = 5;
  localparam int PORT_IDX_W = 3;

  // port indices, also the bit positions in a port vector
  localparam int PORT_N = 0;
  localparam int PORT_S = 1;
  localparam int PORT_W = 2;
  localparam int PORT_E = 3;
  localparam int PORT_L = 4;

  // mesh coordinate and payload widths
  localparam int COORD_W   = 3;
  localparam int PAYLOAD_W = 16;

  // position of this router in the mesh
  localparam logic [COORD_W-1:0] ROUTER_X = 3'd3;
  localparam logic [COORD_W-1:0] ROUTER_Y = 3'd3;

  // index of one port, used by the round-robin pointer
  typedef logic [PORT_IDX_W-1:0] port_idx_t;

  // single-flit packet, destination first
  typedef struct packed {
    logic [COORD_W-1:0]   dest_x;
    logic [COORD_W-1:0]   dest_y;
    logic [PAYLOAD_W-1:0] payload;
  } flit_t;

  // one bit per port, for requests, grants and link strobes
  typedef logic [NUM_PORTS-1:0] port_vec_t;

endpackage

//--- hw/input_port.sv
// ----------------------------------------
// input port
// four-phase receiver with a one-flit slot,
// xy route raised as a one-hot request
// ----------------------------------------

`timescale 1ns/1ps

module input_port (
  input  logic               clk,
  input  logic               reset_i,
  input  logic               req_i,
  input  noc_pkg::flit_t     flit_i,
  output logic               ack_o,
  input  noc_pkg::port_vec_t grant_i,
  output noc_pkg::port_vec_t route_req_o,
  output noc_pkg::flit_t     slot_flit_o
);

  logic               full_q;
  logic               ack_q;
  noc_pkg::flit_t     slot_q;
  noc_pkg::port_vec_t route_vec;
  logic               load;

  // take a new flit only with the link in phase one and the slot free
  assign load = req_i && !ack_q && !full_q;

  // link handshake and slot state
  always_ff @(posedge clk) begin
    if (reset_i) begin
      full_q <= 1'b0;
      ack_q  <= 1'b0;
    end else begin
      if (load) begin
        ack_q <= 1'b1;
      end else if (ack_q && !req_i) begin
        ack_q <= 1'b0;
      end

      if (load) begin
        full_q <= 1'b1;
      end else if (|grant_i) begin
        full_q <= 1'b0;
      end
    end
  end

  // payload slot
  always_ff @(posedge clk) begin
    if (load) begin
      slot_q <= flit_i;
    end
  end

  // xy routing, x first then y
  always_comb begin
    route_vec = '0;
    if (slot_q.dest_x > noc_pkg::ROUTER_X) begin
      route_vec[noc_pkg::PORT_E] = 1'b1;
    end else if (slot_q.dest_x < noc_pkg::ROUTER_X) begin
      route_vec[noc_pkg::PORT_W] = 1'b1;
    end else if (slot_q.dest_y > noc_pkg::ROUTER_Y) begin
      route_vec[noc_pkg::PORT_N] = 1'b1;
    end else if (slot_q.dest_y < noc_pkg::ROUTER_Y) begin
      route_vec[noc_pkg::PORT_S] = 1'b1;
    end else begin
      route_vec[noc_pkg::PORT_L] = 1'b1;
    end
  end

  assign route_req_o = full_q ? route_vec : '0;
  assign slot_flit_o = slot_q;
  assign ack_o       = ack_q;

  // only one output may take the flit, and only a stored one
  a_grant_onehot: assert property (@(posedge clk) disable iff (reset_i)
    $onehot0(grant_i));
  a_grant_when_full: assert property (@(posedge clk) disable iff (reset_i)
    (|grant_i) |-> full_q);

endmodule

//--- hw/output_port/rr_arbiter.sv
// ----------------------------------------
// round-robin arbiter
// five requesters, priority rotates past each winner
// ----------------------------------------

`timescale 1ns/1ps

module rr_arbiter (
  input  logic               clk,
  input  logic               reset_i,
  input  logic               enable_i,
  input  noc_pkg::port_vec_t cand_i,
  output noc_pkg::port_vec_t grant_o
);

  noc_pkg::port_idx_t ptr_q;
  noc_pkg::port_idx_t winner;
  noc_pkg::port_idx_t ptr_next;

  // scan upward from the pointer, wrapping after the local port
  always_comb begin
    int   idx;
    logic found;
    grant_o = '0;
    winner  = ptr_q;
    found   = 1'b0;
    for (int i = 0; i < noc_pkg::NUM_PORTS; i++) begin
      idx = int'(ptr_q) + i;
      if (idx >= noc_pkg::NUM_PORTS) begin
        idx = idx - noc_pkg::NUM_PORTS;
      end
      if (enable_i && !found && cand_i[idx]) begin
        found        = 1'b1;
        grant_o[idx] = 1'b1;
        winner       = noc_pkg::port_idx_t'(idx);
      end
    end
  end

  // winner plus one modulo five
  always_comb begin
    if (winner == noc_pkg::port_idx_t'(noc_pkg::PORT_L)) begin
      ptr_next = noc_pkg::port_idx_t'(noc_pkg::PORT_N);
    end else begin
      ptr_next = winner + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      ptr_q <= noc_pkg::port_idx_t'(noc_pkg::PORT_N);
    end else if (|grant_o) begin
      ptr_q <= ptr_next;
    end
  end

  // never more than one winner, and only among the candidates
  a_grant_legal: assert property (@(posedge clk) disable iff (reset_i)
    $onehot0(grant_o) && ((grant_o & ~cand_i) == '0));

  // the wrapped scan reaches every candidate from any pointer
  a_grant_busy: assert property (@(posedge clk) disable iff (reset_i)
    (|grant_o) == (enable_i && (|cand_i)));

endmodule

//--- hw/output_port/output_port.sv
// ----------------------------------------
// output port
// allocates one input, latches its flit and
// sends it on a four-phase link
// ----------------------------------------

`timescale 1ns/1ps

module output_port (
  input  logic               clk,
  input  logic               reset_i,
  input  noc_pkg::port_vec_t cand_i,
  input  noc_pkg::flit_t     slot_flits_i [noc_pkg::NUM_PORTS],
  output noc_pkg::port_vec_t grant_o,
  output logic               req_o,
  input  logic               ack_i,
  output noc_pkg::flit_t     flit_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WAIT_ACK_HI,
    ST_WAIT_ACK_LO
  } state_t;

  state_t             state_q;
  noc_pkg::port_vec_t grant;
  noc_pkg::flit_t     sel_flit;
  noc_pkg::flit_t     flit_q;
  logic               arb_en;

  // arbitrate only while the link is free
  assign arb_en = (state_q == ST_IDLE);

  rr_arbiter u_arb (
    .clk      (clk),
    .reset_i  (reset_i),
    .enable_i (arb_en),
    .cand_i   (cand_i),
    .grant_o  (grant)
  );

  // switch mux over a one-hot grant
  always_comb begin
    sel_flit = '0;
    for (int i = 0; i < noc_pkg::NUM_PORTS; i++) begin
      if (grant[i]) begin
        sel_flit = slot_flits_i[i];
      end
    end
  end

  // sender fsm
  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (|grant) begin
            state_q <= ST_WAIT_ACK_HI;
          end
        end
        ST_WAIT_ACK_HI: begin
          if (ack_i) begin
            state_q <= ST_WAIT_ACK_LO;
          end
        end
        ST_WAIT_ACK_LO: begin
          if (!ack_i) begin
            state_q <= ST_IDLE;
          end
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  // grant is only non-zero while idle
  always_ff @(posedge clk) begin
    if (|grant) begin
      flit_q <= sel_flit;
    end
  end

  assign grant_o = grant;
  assign req_o   = (state_q == ST_WAIT_ACK_HI);
  assign flit_o  = flit_q;

  // downstream must see ack before req drops, with the flit held
  a_req_hold: assert property (@(posedge clk) disable iff (reset_i)
    (req_o && !ack_i) |=> (req_o && $stable(flit_o)));

endmodule

//--- hw/router_top.sv
// ----------------------------------------
// five-port mesh router core
// input slots, xy routing and per-output
// round-robin allocation
// ----------------------------------------

`timescale 1ns/1ps

module router_top (
  input  logic               clk,
  input  logic               reset_i,
  input  noc_pkg::port_vec_t in_req_i,
  input  noc_pkg::flit_t     in_flit_i [noc_pkg::NUM_PORTS],
  output noc_pkg::port_vec_t in_ack_o,
  output noc_pkg::port_vec_t out_req_o,
  output noc_pkg::flit_t     out_flit_o [noc_pkg::NUM_PORTS],
  input  noc_pkg::port_vec_t out_ack_i
);

  // indexed by input port
  noc_pkg::port_vec_t route_req [noc_pkg::NUM_PORTS];
  noc_pkg::port_vec_t in_grant  [noc_pkg::NUM_PORTS];
  noc_pkg::flit_t     slot_flit [noc_pkg::NUM_PORTS];

  // indexed by output port
  noc_pkg::port_vec_t cand      [noc_pkg::NUM_PORTS];
  noc_pkg::port_vec_t out_grant [noc_pkg::NUM_PORTS];

  // transpose requests (input to output) and grants (output to input)
  always_comb begin
    for (int o = 0; o < noc_pkg::NUM_PORTS; o++) begin
      for (int i = 0; i < noc_pkg::NUM_PORTS; i++) begin
        cand[o][i]     = route_req[i][o];
        in_grant[i][o] = out_grant[o][i];
      end
    end
  end

  for (genvar p = 0; p < noc_pkg::NUM_PORTS; p++) begin : g_port
    input_port u_in (
      .clk         (clk),
      .reset_i     (reset_i),
      .req_i       (in_req_i[p]),
      .flit_i      (in_flit_i[p]),
      .ack_o       (in_ack_o[p]),
      .grant_i     (in_grant[p]),
      .route_req_o (route_req[p]),
      .slot_flit_o (slot_flit[p])
    );

    output_port u_out (
      .clk          (clk),
      .reset_i      (reset_i),
      .cand_i       (cand[p]),
      .slot_flits_i (slot_flit),
      .grant_o      (out_grant[p]),
      .req_o        (out_req_o[p]),
      .ack_i        (out_ack_i[p]),
      .flit_o       (out_flit_o[p])
    );
  end

endmodule

//--- bench/router_tb.sv
// ----------------------------------------
// router testbench
// drives the input links from a stimulus file,
// models the output sinks and checks deliveries
// ----------------------------------------

`timescale 1ns/1ps

module router_tb;

  localparam int MAX_REC = 64;

  logic               clk;
  logic               reset_i;
  noc_pkg::port_vec_t in_req;
  noc_pkg::flit_t     in_flit [noc_pkg::NUM_PORTS];
  noc_pkg::port_vec_t in_ack_o;
  noc_pkg::port_vec_t out_req_o;
  noc_pkg::flit_t     out_flit_o [noc_pkg::NUM_PORTS];
  noc_pkg::port_vec_t out_ack;

  // stimulus records
  int                           n_rec;
  int                           rec_grp [MAX_REC];
  int                           rec_in  [MAX_REC];
  int                           rec_out [MAX_REC];
  logic [noc_pkg::COORD_W-1:0]   rec_dx  [MAX_REC];
  logic [noc_pkg::COORD_W-1:0]   rec_dy  [MAX_REC];
  logic [noc_pkg::PAYLOAD_W-1:0] rec_pl  [MAX_REC];
  bit                           rec_done [MAX_REC];
  int                           sel [$];

  int                 seed;
  int                 errors;
  int                 cycles;
  int                 limit;
  int                 n_deliv;
  int                 sent_cnt;
  noc_pkg::port_vec_t hold;

  // round-robin model of the local output
  int                 rr_ptr;
  noc_pkg::port_vec_t rr_pend;
  // back-pressure and overlap watches
  bit                 bp_watch;
  int                 bp_port;
  int                 bp_order [$];
  bit                 ovl_watch;
  bit                 ovl_seen;

  // previous-cycle values for the link monitors
  noc_pkg::port_vec_t prev_ack;
  noc_pkg::port_vec_t prev_req;
  noc_pkg::flit_t     prev_flit [noc_pkg::NUM_PORTS];
  noc_pkg::port_vec_t ack_seen;
  logic               reset_q;

  router_top DUT (
    .clk        (clk),
    .reset_i    (reset_i),
    .in_req_i   (in_req),
    .in_flit_i  (in_flit),
    .in_ack_o   (in_ack_o),
    .out_req_o  (out_req_o),
    .out_flit_o (out_flit_o),
    .out_ack_i  (out_ack)
  );

  always #5 clk = ~clk;

  // link monitors and timeout
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > 1 && (reset_i || reset_q)) begin
      if (in_ack_o !== '0 || out_req_o !== '0) begin
        $display("error reset in_ack_o %h out_req_o %h", in_ack_o, out_req_o);
        errors++;
      end
    end
    if (!reset_i && !reset_q) begin
      for (int p = 0; p < noc_pkg::NUM_PORTS; p++) begin
        if (!prev_ack[p] && in_ack_o[p] && !in_req[p]) begin
          $display("in_ack_o[%0d] rose while in_req_i was low", p);
          errors++;
        end
        if (prev_ack[p] && !in_ack_o[p] && in_req[p]) begin
          $display("in_ack_o[%0d] fell while in_req_i was high", p);
          errors++;
        end
        if (!prev_req[p] && out_req_o[p]) begin
          ack_seen[p] = 1'b0;
        end
        if (prev_req[p] && !out_req_o[p] && !ack_seen[p]) begin
          $display("out_req_o[%0d] fell before out_ack_i was high", p);
          errors++;
        end
        if (prev_req[p] && out_req_o[p] && out_flit_o[p] != prev_flit[p]) begin
          $display("error out_flit_o[%0d] changed %h -> %h", p, prev_flit[p], out_flit_o[p]);
          errors++;
        end
        if (out_req_o[p] && out_ack[p]) begin
          ack_seen[p] = 1'b1;
        end
      end
      if (bp_watch && in_ack_o[bp_port]) begin
        $display("in_ack_o[%0d] rose while its output was still blocked", bp_port);
        errors++;
      end
      if (ovl_watch && $countones(out_req_o) >= 2) begin
        ovl_seen = 1'b1;
      end
    end
    prev_ack  = in_ack_o;
    prev_req  = out_req_o;
    prev_flit = out_flit_o;
    reset_q   = reset_i;
    if (limit > 0 && cycles > limit) begin
      $display("timeout after %0d cycles, %0d errors", cycles, errors);
      $display("TB FAILED");
      $finish;
    end
  end

  // match a delivered flit to its record by payload
  function automatic void record_delivery(input int p, input noc_pkg::flit_t f);
    int k;
    int exp_win;
    k = -1;
    for (int i = 0; i < n_rec; i++) begin
      if (rec_pl[i] == f.payload) begin
        k = i;
      end
    end
    if (k < 0) begin
      $display("unknown payload %h delivered on output %0d", f.payload, p);
      errors++;
      return;
    end
    if (rec_done[k]) begin
      $display("payload %h delivered twice", f.payload);
      errors++;
    end
    rec_done[k] = 1'b1;
    if (p != rec_out[k]) begin
      $display("error out_req_o port for %h exp %h got %h", f.payload, rec_out[k], p);
      errors++;
    end
    if (f != {rec_dx[k], rec_dy[k], rec_pl[k]}) begin
      $display("error out_flit_o[%0d] exp %h got %h", p, {rec_dx[k], rec_dy[k], rec_pl[k]}, f);
      errors++;
    end
    if (p == noc_pkg::PORT_L) begin
      if (rr_pend[rec_in[k]]) begin
        exp_win = -1;
        for (int j = 0; j < noc_pkg::NUM_PORTS; j++) begin
          if (exp_win < 0 && rr_pend[(rr_ptr + j) % noc_pkg::NUM_PORTS]) begin
            exp_win = (rr_ptr + j) % noc_pkg::NUM_PORTS;
          end
        end
        if (exp_win != rec_in[k]) begin
          $display("error local grant input exp %h got %h", exp_win, rec_in[k]);
          errors++;
        end
        rr_pend[rec_in[k]] = 1'b0;
      end
      rr_ptr = (rec_in[k] + 1) % noc_pkg::NUM_PORTS;
    end
    if (rec_grp[k] == 2) begin
      bp_order.push_back(k);
    end
    n_deliv++;
  endfunction

  // downstream sink with a random ack delay
  task automatic sink_loop(input int p);
    int dly;
    forever begin
      @(posedge clk);
      if (!reset_i && out_req_o[p] && !hold[p]) begin
        dly = $random(seed) & 3;
        repeat (dly) @(posedge clk);
        record_delivery(p, out_flit_o[p]);
        #1 out_ack[p] = 1'b1;
        do @(posedge clk); while (out_req_o[p]);
        #1 out_ack[p] = 1'b0;
      end
    end
  endtask

  // upstream four-phase sender
  task automatic send_rec(input int k);
    int p;
    p = rec_in[k];
    @(posedge clk);
    #1;
    in_flit[p] = {rec_dx[k], rec_dy[k], rec_pl[k]};
    in_req[p]  = 1'b1;
    do @(posedge clk); while (!in_ack_o[p]);
    #1 in_req[p] = 1'b0;
    do @(posedge clk); while (in_ack_o[p]);
    sent_cnt++;
  endtask

  function automatic void pick_group(input int g);
    sel.delete();
    for (int i = 0; i < n_rec; i++) begin
      if (rec_grp[i] == g) begin
        sel.push_back(i);
      end
    end
  endfunction

  task automatic wait_count(input int target, input bit use_deliv);
    while ((use_deliv ? n_deliv : sent_cnt) < target) @(posedge clk);
  endtask

  task automatic send_parallel(input int first);
    for (int j = first; j < sel.size(); j++) begin
      automatic int k = sel[j];
      fork
        send_rec(k);
      join_none
    end
  endtask

  task automatic read_stimulus();
    int    fd;
    int    g;
    int    ip;
    int    op;
    int    dx;
    int    dy;
    int    pl;
    string line;
    fd = $fopen("bench/router_stimulus.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file");
      errors++;
      return;
    end
    while (!$feof(fd) && n_rec < MAX_REC) begin
      if ($fgets(line, fd) > 0 && $sscanf(line, "%d %d %d %d %h %d",
          g, ip, dx, dy, pl, op) == 6) begin
        rec_grp[n_rec] = g;
        rec_in[n_rec]  = ip;
        rec_dx[n_rec]  = dx[noc_pkg::COORD_W-1:0];
        rec_dy[n_rec]  = dy[noc_pkg::COORD_W-1:0];
        rec_pl[n_rec]  = pl[noc_pkg::PAYLOAD_W-1:0];
        rec_out[n_rec] = op;
        n_rec++;
      end
    end
    $fclose(fd);
  endtask

  task automatic run_groups();
    int base;
    int hp;
    int lead;
    // routing with one flit at a time
    pick_group(0);
    foreach (sel[j]) begin
      send_rec(sel[j]);
    end
    wait_count(sel.size(), 1'b1);
    // round robin on the local output
    pick_group(1);
    if (sel.size() > 0) begin
      // lead with the west input so the pointer starts mid-way and wraps
      for (int j = 1; j < sel.size(); j++) begin
        if (rec_in[sel[j]] == noc_pkg::PORT_W) begin
          lead   = sel[j];
          sel[j] = sel[0];
          sel[0] = lead;
        end
      end
      base = n_deliv;
      hold[noc_pkg::PORT_L] = 1'b1;
      send_rec(sel[0]);
      while (!out_req_o[noc_pkg::PORT_L]) @(posedge clk);
      for (int j = 1; j < sel.size(); j++) begin
        rr_pend[rec_in[sel[j]]] = 1'b1;
      end
      sent_cnt = 0;
      send_parallel(1);
      wait_count(sel.size() - 1, 1'b0);
      #1 hold[noc_pkg::PORT_L] = 1'b0;
      wait_count(base + sel.size(), 1'b1);
    end
    // back-pressure on one input
    pick_group(2);
    if (sel.size() == 3) begin
      base = n_deliv;
      hp = rec_out[sel[0]];
      hold[hp] = 1'b1;
      send_rec(sel[0]);
      while (!out_req_o[hp]) @(posedge clk);
      send_rec(sel[1]);
      bp_port  = rec_in[sel[2]];
      bp_watch = 1'b1;
      send_parallel(2);
      repeat (20) @(posedge clk);
      bp_watch = 1'b0;
      #1 hold[hp] = 1'b0;
      wait_count(base + 3, 1'b1);
      foreach (bp_order[j]) begin
        if (bp_order[j] != sel[j]) begin
          $display("error out_flit_o[%0d] order exp %h got %h", hp,
                   rec_pl[sel[j]], rec_pl[bp_order[j]]);
          errors++;
        end
      end
    end
    // all five outputs busy together
    pick_group(3);
    base = n_deliv;
    ovl_watch = 1'b1;
    send_parallel(0);
    wait_count(base + sel.size(), 1'b1);
    ovl_watch = 1'b0;
    if (sel.size() > 1 && !ovl_seen) begin
      $display("no two outputs were active at the same time");
      errors++;
    end
  endtask

  initial begin
    clk = 1'b0;
    reset_i = 1'b1;
    in_req = '0;
    out_ack = '0;
    for (int p = 0; p < noc_pkg::NUM_PORTS; p++) begin
      in_flit[p] = '0;
    end
    seed = 32'h75ac;
    errors = 0;
    cycles = 0;
    limit = 0;
    n_rec = 0;
    n_deliv = 0;
    sent_cnt = 0;
    hold = '0;
    rr_ptr = noc_pkg::PORT_N;
    rr_pend = '0;
    bp_watch = 1'b0;
    bp_port = 0;
    ovl_watch = 1'b0;
    ovl_seen = 1'b0;
    prev_ack = '0;
    prev_req = '0;
    ack_seen = '0;
    reset_q = 1'b1;
    read_stimulus();
    limit = 60 * n_rec + 200;
    for (int p = 0; p < noc_pkg::NUM_PORTS; p++) begin
      automatic int q = p;
      fork
        sink_loop(q);
      join_none
    end
    repeat (2) @(posedge clk);
    #1 reset_i = 1'b0;
    run_groups();
    repeat (5) @(posedge clk);
    for (int i = 0; i < n_rec; i++) begin
      if (!rec_done[i]) begin
        $display("payload %h was never delivered", rec_pl[i]);
        errors++;
      end
    end
    $display("records %0d delivered %0d errors %0d", n_rec, n_deliv, errors);
    if (errors == 0 && n_rec > 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- bench/router_stimulus.txt
# columns: group input_port dest_x dest_y payload(hex) expected_output
# groups: 0 routing, 1 round robin, 2 back-pressure, 3 concurrency
0 4 5 3 1001 3
0 4 1 3 1002 2
0 0 3 6 1003 0
0 1 3 0 1004 1
0 2 3 3 1005 4
0 3 7 7 1006 3
0 0 0 5 1007 2
0 2 3 4 1008 0
0 3 3 2 1009 1
0 1 3 3 100a 4
1 4 3 3 2001 4
1 0 3 3 2002 4
1 1 3 3 2003 4
1 2 3 3 2004 4
1 3 3 3 2005 4
2 2 6 1 3001 3
2 2 4 3 3002 3
2 2 5 5 3003 3
3 0 3 3 4001 4
3 1 6 2 4002 3
3 2 3 7 4003 0
3 3 0 0 4004 2
3 4 3 1 4005 1

//--- flist.f
common/noc_pkg.sv
hw/input_port.sv
hw/output_port/rr_arbiter.sv
hw/output_port/output_port.sv
hw/router_top.sv
bench/router_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the router testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing \
  -f flist.f \
  --top-module router_tb \
  --Mdir build \
  -o router_sim > build.log 2>&1 \
  || { echo "build failed, see build.log"; exit 1; }

./build/router_sim > sim.log 2>&1 \
  || echo "simulator exited with an error"

grep -qx "TB PASSED" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }
